// File: design/tile_pkg.sv
/*
  Shared types and sizes for the systolic tile orchestrator.
  All dimensions and coordinates are 16-bit unsigned, so N, K, M and BLOCK_M
  must each fit in 16 bits. BLOCK_M is expected to be a nonzero multiple of
  tile_size. An effective tile edge is 4 bits wide, which limits tile_size to 15.
*/
`default_nettype none

package tile_pkg;

  // Systolic array edge, in elements
  localparam int tile_size = 8;

  // Loaded B blocks that can wait for the sequencer
  localparam int b_queue_depth = 4;

  // Finished C tiles that can wait for write-back
  localparam int c_queue_depth = 4;

  typedef logic [15:0] dim_t; // Dimension or coordinate
  typedef logic [3:0]  eff_t; // Effective tile edge, 1..tile_size

  // Problem shape, sampled once per run
  typedef struct packed {
    dim_t n;       // Rows of A and C
    dim_t k;       // Shared inner dimension
    dim_t m;       // Columns of B and C
    dim_t block_m; // Width of one B column block
  } dims_t;

  // One output tile of C
  typedef struct packed {
    dim_t i0;    // Row origin
    dim_t j0;    // Column origin
    eff_t n_eff; // Valid rows that shrink on the bottom edge
    eff_t m_eff; // Valid columns that shrink on a block or matrix edge
  } tile_info_t;

endpackage

`default_nettype wire

// File: design/tile_queue.sv
/*
  Small circular FIFO used between pipeline stages.
  The front entry is visible combinationally while empty is low.
  Producers must not push while full and consumers must not pop while empty.
  A simultaneous push and pop keeps the count unchanged.
*/
`timescale 1ns/1ps
`default_nettype none

module tile_queue #(
  parameter int  depth   = 4,
  parameter type entry_t = logic [15:0]
) (
  input  logic   clk,
  input  logic   rstn,
  input  logic   push,      // One-cycle write strobe
  input  entry_t push_data,
  input  logic   pop,       // One-cycle read strobe
  output entry_t front,     // Oldest entry
  output logic   empty,
  output logic   full
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  entry_t             mem [depth]; // Entry storage
  logic [ptr_w-1:0]   wr_ptr;
  logic [ptr_w-1:0]   rd_ptr;
  logic [cnt_w-1:0]   count;
  logic               do_push;
  logic               do_pop;

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign empty = (count == '0);
  assign full  = (count == cnt_w'(depth));
  assign front = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1; // Wrap
      if (do_pop)  rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      if (do_push && !do_pop)      count <= count + 1'b1;
      else if (do_pop && !do_push) count <= count - 1'b1;
    end
  end

  // Producer side must respect the full flag
  a_no_overflow : assert property (@(posedge clk) disable iff (!rstn) push |-> !full)
    else $error("tile_queue: push while full");

  // Consumer side must respect the empty flag
  a_no_underflow : assert property (@(posedge clk) disable iff (!rstn) pop |-> !empty)
    else $error("tile_queue: pop while empty");

endmodule

`default_nettype wire

// File: design/block_loader.sv
/*
  Requests B column blocks from the external loader, one at a time.
  Block origins run 0, BLOCK_M, 2*BLOCK_M while below M.
  Each finished block origin is pushed into the B queue on the cycle after ld_done.
  If the queue is full at ld_done the block is held and pushed once space frees up,
  and no new request goes out until then. M is assumed nonzero.
*/
`timescale 1ns/1ps
`default_nettype none

module block_loader (
  input  logic            clk,
  input  logic            rstn,
  input  logic            go,             // Run level from the top
  input  tile_pkg::dims_t dims,
  output logic            loader_req,     // One-cycle request pulse
  output tile_pkg::dim_t  loader_j_block, // Held until ld_done
  input  logic            ld_done,
  output logic            q_push,
  output tile_pkg::dim_t  q_data,
  input  logic            q_full,
  output logic            finished
);
  import tile_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_request, // Waiting for queue space
    st_wait,    // Load outstanding
    st_finished
  } state_e;

  state_e      state;
  dim_t        j_next; // Next block origin to request
  logic        more;   // j_next is still below M
  logic        held;   // Loaded block not yet pushed
  logic [16:0] sum_j;  // Extra bit so a large M cannot wrap

  assign sum_j = {1'b0, loader_j_block} + {1'b0, dims.block_m};

  // Not finished while the last push is still landing in the queue
  assign finished = (state == st_finished) && !q_push;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state          <= st_idle;
      loader_req     <= 1'b0;
      loader_j_block <= '0;
      q_push         <= 1'b0;
      q_data         <= '0;
      j_next         <= '0;
      more           <= 1'b0;
      held           <= 1'b0;
    end else begin
      loader_req <= 1'b0; // Pulses by default
      q_push     <= 1'b0;
      case (state)
        st_idle: begin
          if (go) begin
            loader_req     <= 1'b1; // First block at column 0
            loader_j_block <= '0;
            state          <= st_wait;
          end
        end
        st_wait: begin
          if (ld_done) begin
            j_next <= sum_j[15:0];
            more   <= (sum_j < {1'b0, dims.m});
            if (q_full) begin
              held  <= 1'b1; // Keep origin on loader_j_block
              state <= st_request;
            end else begin
              q_push <= 1'b1;
              q_data <= loader_j_block;
              if (sum_j >= {1'b0, dims.m}) begin
                state <= st_finished;
              end else begin
                loader_req     <= 1'b1; // Back-to-back request
                loader_j_block <= sum_j[15:0];
              end
            end
          end
        end
        st_request: begin
          if (held) begin
            if (!q_full) begin
              q_push <= 1'b1;
              q_data <= loader_j_block;
              held   <= 1'b0;
              if (!more) state <= st_finished;
            end
          end else if (!q_full) begin
            loader_req     <= 1'b1;
            loader_j_block <= j_next;
            state          <= st_wait;
          end
        end
        st_finished: begin
          if (!go) state <= st_idle; // Rearm for the next run
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/tile_sequencer.sv
/*
  Walks the output tiles of each loaded B block and drives the compute engine.
  Inside a block j0 steps by tile_size first, then i0, both row-major.
  Effective sizes clip at the N edge and at min(block end, M).
  start_tile is withheld while the C queue is full, so the push after tile_done
  always finds space. Only one tile is outstanding at a time.
*/
`timescale 1ns/1ps
`default_nettype none

module tile_sequencer (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 go,
  input  tile_pkg::dims_t      dims,
  input  logic                 b_empty,
  input  tile_pkg::dim_t       b_front,         // Origin of next loaded block
  output logic                 b_pop,
  input  logic                 loads_finished,
  output logic                 start_tile,      // One-cycle pulse
  output tile_pkg::tile_info_t compute_tile,    // Held until tile_done
  output tile_pkg::dim_t       compute_k_total,
  input  logic                 tile_done,
  output logic                 c_push,
  output tile_pkg::tile_info_t c_data,
  input  logic                 c_full,
  output logic                 finished
);
  import tile_pkg::*;

  typedef enum logic [2:0] {
    st_idle,     // Looking for the next block
    st_prepare,  // Latch tile sizes
    st_run,      // Start compute when the C queue has space
    st_wait,     // Tile in flight
    st_finished
  } state_e;

  state_e      state;
  dim_t        blk_j; // Origin of the current block
  dim_t        i0;
  dim_t        j0;
  logic [16:0] blk_sum;
  logic [16:0] blk_end; // Column limit of this block
  logic [16:0] rem_n;
  logic [16:0] rem_m;
  logic [16:0] step_i;
  logic [16:0] step_j;
  eff_t        n_eff_c;
  eff_t        m_eff_c;

  always_comb begin
    blk_sum = {1'b0, blk_j} + {1'b0, dims.block_m};
    blk_end = (blk_sum < {1'b0, dims.m}) ? blk_sum : {1'b0, dims.m}; // Last block is ragged
    rem_n   = {1'b0, dims.n} - {1'b0, i0};
    rem_m   = blk_end - {1'b0, j0};
    n_eff_c = (rem_n >= 17'(tile_size)) ? eff_t'(tile_size) : eff_t'(rem_n);
    m_eff_c = (rem_m >= 17'(tile_size)) ? eff_t'(tile_size) : eff_t'(rem_m);
    step_i  = {1'b0, i0} + 17'(tile_size);
    step_j  = {1'b0, j0} + 17'(tile_size);
  end

  assign finished = (state == st_finished);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state           <= st_idle;
      blk_j           <= '0;
      i0              <= '0;
      j0              <= '0;
      b_pop           <= 1'b0;
      start_tile      <= 1'b0;
      compute_tile    <= '0;
      compute_k_total <= '0;
      c_push          <= 1'b0;
      c_data          <= '0;
    end else begin
      b_pop      <= 1'b0;
      start_tile <= 1'b0;
      c_push     <= 1'b0;
      case (state)
        st_idle: begin
          if (go) begin
            if (!b_empty) begin
              b_pop <= 1'b1; // Take the block, start at its top-left tile
              blk_j <= b_front;
              i0    <= '0;
              j0    <= b_front;
              state <= st_prepare;
            end else if (loads_finished) begin
              state <= st_finished; // No block left to come
            end
          end
        end
        st_prepare: begin
          compute_tile    <= '{i0: i0, j0: j0, n_eff: n_eff_c, m_eff: m_eff_c};
          compute_k_total <= dims.k;
          state           <= st_run;
        end
        st_run: begin
          if (!c_full) begin
            start_tile <= 1'b1;
            state      <= st_wait;
          end
        end
        st_wait: begin
          if (tile_done) begin
            c_push <= 1'b1;
            c_data <= compute_tile;
            if (step_j < blk_end) begin
              j0    <= step_j[15:0]; // Next column in the block
              state <= st_prepare;
            end else if (step_i < {1'b0, dims.n}) begin
              i0    <= step_i[15:0]; // Next tile row
              j0    <= blk_j;
              state <= st_prepare;
            end else begin
              state <= st_idle; // Block exhausted
            end
          end
        end
        st_finished: begin
          if (!go) state <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  // A zero edge means the walk stepped past N or past the block limit
  a_eff_nonzero : assert property (@(posedge clk) disable iff (!rstn)
    start_tile |-> (compute_tile.n_eff != '0) && (compute_tile.m_eff != '0))
    else $error("tile_sequencer: empty tile started");

endmodule

`default_nettype wire

// File: design/store_issuer.sv
/*
  Pops finished tile descriptors and starts the write-back engine for each.
  store_tile holds the descriptor until wr_done, then one recovery cycle follows.
  finished only reports an idle issuer; the top combines it with the
  sequencer's finished level and the empty C queue.
*/
`timescale 1ns/1ps
`default_nettype none

module store_issuer (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 go,
  input  logic                 c_empty,
  input  tile_pkg::tile_info_t c_front,
  output logic                 c_pop,
  output logic                 start_store, // One-cycle pulse
  output tile_pkg::tile_info_t store_tile,  // Held until wr_done
  input  logic                 wr_done,
  output logic                 finished
);
  import tile_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_wait,    // Write-back in flight
    st_recover  // One spare cycle before the next pop
  } state_e;

  state_e state;

  assign finished = (state == st_idle);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state       <= st_idle;
      c_pop       <= 1'b0;
      start_store <= 1'b0;
      store_tile  <= '0;
    end else begin
      c_pop       <= 1'b0;
      start_store <= 1'b0;
      case (state)
        st_idle: begin
          if (go && !c_empty) begin
            store_tile  <= c_front; // Front is valid while not empty
            c_pop       <= 1'b1;
            start_store <= 1'b1;
            state       <= st_wait;
          end
        end
        st_wait:    if (wr_done) state <= st_recover;
        st_recover: state <= st_idle;
        default:    state <= st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/tile_controller.sv
/*
  Top of the tile orchestrator: run control plus the three overlapped stages.
  start is taken only while busy is low, and dims are sampled with it.
  busy rises the cycle after start and falls in the cycle done pulses.
  done follows all stages finished with both queues empty.
  Each engine port uses a request pulse answered by a done pulse.
*/
`timescale 1ns/1ps
`default_nettype none

module tile_controller (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 start,
  input  tile_pkg::dims_t      dims,
  output logic                 busy,
  output logic                 done,
  // Loader engine
  output logic                 loader_req,
  output tile_pkg::dim_t       loader_j_block,
  input  logic                 ld_done,
  // Compute engine
  output logic                 start_tile,
  output tile_pkg::tile_info_t compute_tile,
  output tile_pkg::dim_t       compute_k_total,
  input  logic                 tile_done,
  // Store engine
  output logic                 start_store,
  output tile_pkg::tile_info_t store_tile,
  input  logic                 wr_done
);
  import tile_pkg::*;

  dims_t      dims_q;   // Shape of the active run
  logic       go;
  logic       all_fin;
  logic       ld_fin;
  logic       seq_fin;
  logic       st_fin;
  // B queue between loader and sequencer
  logic       b_push;
  dim_t       b_data;
  logic       b_pop;
  dim_t       b_front;
  logic       b_empty;
  logic       b_full;
  // C queue between sequencer and store issuer
  logic       c_push;
  tile_info_t c_data;
  logic       c_pop;
  tile_info_t c_front;
  logic       c_empty;
  logic       c_full;

  assign go      = busy;
  assign all_fin = ld_fin && seq_fin && st_fin && b_empty && c_empty;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      busy   <= 1'b0;
      done   <= 1'b0;
      dims_q <= '0;
    end else begin
      done <= 1'b0;
      if (start && !busy) begin
        busy   <= 1'b1; // Start during a run is ignored
        dims_q <= dims;
      end else if (busy && all_fin) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
    end
  end

  block_loader u_loader (
    .clk, .rstn, .go,
    .dims           (dims_q),
    .loader_req, .loader_j_block, .ld_done,
    .q_push         (b_push),
    .q_data         (b_data),
    .q_full         (b_full),
    .finished       (ld_fin)
  );

  tile_queue #(.depth(b_queue_depth), .entry_t(dim_t)) b_queue (
    .clk, .rstn,
    .push      (b_push),
    .push_data (b_data),
    .pop       (b_pop),
    .front     (b_front),
    .empty     (b_empty),
    .full      (b_full)
  );

  tile_sequencer u_sequencer (
    .clk, .rstn, .go,
    .dims            (dims_q),
    .b_empty, .b_front, .b_pop,
    .loads_finished  (ld_fin),
    .start_tile, .compute_tile, .compute_k_total, .tile_done,
    .c_push, .c_data, .c_full,
    .finished        (seq_fin)
  );

  tile_queue #(.depth(c_queue_depth), .entry_t(tile_info_t)) c_queue (
    .clk, .rstn,
    .push      (c_push),
    .push_data (c_data),
    .pop       (c_pop),
    .front     (c_front),
    .empty     (c_empty),
    .full      (c_full)
  );

  store_issuer u_store (
    .clk, .rstn, .go,
    .c_empty, .c_front, .c_pop,
    .start_store, .store_tile, .wr_done,
    .finished    (st_fin)
  );

  // No stage may still be talking to an engine once the run has closed
  a_req_in_run : assert property (@(posedge clk) disable iff (!rstn)
    (loader_req || start_tile || start_store) |-> busy)
    else $error("tile_controller: engine request outside a run");

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
/*
  Testbench clock and reset source.
  Clock period is 4 ns. rstn is held low for the first two rising edges
  and released 1 ns after the second one.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rstn
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk; // 4 ns period
  end

  initial begin
    rstn = 1'b0;
    repeat (2) @(posedge clk);
    #1 rstn = 1'b1; // Release away from the edge
  end

endmodule

`default_nettype wire

// File: verification/tile_controller_tb.sv
/*
  Testbench for the tile orchestrator top level.
  Runs a table of problem shapes; engine models answer each request after
  1 to 6 cycles, or 40 cycles on the store side for the back-pressure entry.
  Expected block and tile lists are rebuilt per entry from the tiling rules.
  Inputs change 1 ns after the rising edge, outputs are sampled on the falling edge.
  The run stops at the first mismatch.
*/
`timescale 1ns/1ps
`default_nettype none

module tile_controller_tb;
  import tile_pkg::*;

  typedef struct packed {
    dims_t d;    // N, K, M, BLOCK_M
    logic  slow; // Store engine answers after 40 cycles
  } case_t;

  localparam int num_cases = 6;

  logic       clk;
  logic       rstn;
  logic       start;
  dims_t      dims;
  logic       busy;
  logic       done;
  logic       loader_req;
  dim_t       loader_j_block;
  logic       ld_done;
  logic       start_tile;
  tile_info_t compute_tile;
  dim_t       compute_k_total;
  logic       tile_done;
  logic       start_store;
  tile_info_t store_tile;
  logic       wr_done;

  case_t      cases [num_cases];
  dims_t      cur_dims;         // Shape of the run in progress
  logic       slow_store;
  dim_t       exp_blocks [$];   // Expected loader_j_block order
  tile_info_t exp_tiles [$];    // Expected tile order for compute and store
  int         blk_idx;          // Next expected entry in each stream
  int         cmp_idx;
  int         st_idx;
  int         outstanding;      // Started but not yet written back
  int         max_out;
  int         last_max;         // Peak of the last finished run
  int         done_count;
  int         cycles;
  int         limit;
  int unsigned ld_delay;
  int unsigned ct_delay;
  int unsigned wr_delay;

  tb_clock_gen clk_gen (.clk(clk), .rstn(rstn));

  tile_controller dut0 (
    .clk, .rstn, .start, .dims, .busy, .done,
    .loader_req, .loader_j_block, .ld_done,
    .start_tile, .compute_tile, .compute_k_total, .tile_done,
    .start_store, .store_tile, .wr_done
  );

  task automatic stop_with_error(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_dim(input string name, input dim_t exp, input dim_t act);
    if (exp !== act)
      stop_with_error($sformatf("FAIL %s expected %0d actual %0d", name, exp, act));
  endtask

  task automatic check_tile(input string name, input tile_info_t exp, input tile_info_t act);
    if (exp !== act)
      stop_with_error($sformatf("FAIL %s expected (%0d,%0d,%0d,%0d) actual (%0d,%0d,%0d,%0d)",
        name, exp.i0, exp.j0, exp.n_eff, exp.m_eff,
        act.i0, act.j0, act.n_eff, act.m_eff));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act)
      stop_with_error($sformatf("FAIL %s expected %b actual %b", name, exp, act));
  endtask

  // Blocks at 0, BLOCK_M, ... below M; tiles row-major inside each block
  function automatic void build_expected(input dims_t d);
    int         j_blk;
    int         blk_end;
    int         i0;
    int         j0;
    tile_info_t t;
    exp_blocks.delete();
    exp_tiles.delete();
    for (j_blk = 0; j_blk < int'(d.m); j_blk += int'(d.block_m)) begin
      exp_blocks.push_back(dim_t'(j_blk));
      blk_end = j_blk + int'(d.block_m);
      if (blk_end > int'(d.m)) blk_end = int'(d.m); // Ragged last block
      for (i0 = 0; i0 < int'(d.n); i0 += tile_size) begin
        for (j0 = j_blk; j0 < blk_end; j0 += tile_size) begin
          t.i0    = dim_t'(i0);
          t.j0    = dim_t'(j0);
          t.n_eff = eff_t'((int'(d.n) - i0 < tile_size) ? int'(d.n) - i0 : tile_size);
          t.m_eff = eff_t'((blk_end - j0 < tile_size) ? blk_end - j0 : tile_size);
          exp_tiles.push_back(t);
        end
      end
    end
  endfunction

  // Loader engine
  initial begin
    ld_done = 1'b0;
    forever begin
      @(negedge clk);
      if (loader_req) begin
        ld_delay = 1 + ($urandom % 6);
        repeat (ld_delay) @(posedge clk);
        #1 ld_done = 1'b1;
        @(posedge clk);
        #1 ld_done = 1'b0;
      end
    end
  end

  // Compute engine
  initial begin
    tile_done = 1'b0;
    forever begin
      @(negedge clk);
      if (start_tile) begin
        ct_delay = 1 + ($urandom % 6);
        repeat (ct_delay) @(posedge clk);
        #1 tile_done = 1'b1;
        @(posedge clk);
        #1 tile_done = 1'b0;
      end
    end
  end

  // Store engine that slows down on the back-pressure entry
  initial begin
    wr_done = 1'b0;
    forever begin
      @(negedge clk);
      if (start_store) begin
        wr_delay = slow_store ? 40 : 1 + ($urandom % 6);
        repeat (wr_delay) @(posedge clk);
        #1 wr_done = 1'b1;
        @(posedge clk);
        #1 wr_done = 1'b0;
      end
    end
  end

  // Output monitor for all streams
  initial begin
    blk_idx     = 0;
    cmp_idx     = 0;
    st_idx      = 0;
    outstanding = 0;
    max_out     = 0;
    last_max    = 0;
    done_count  = 0;
    forever begin
      @(negedge clk);
      if (rstn) begin
        if (loader_req) begin
          if (blk_idx >= exp_blocks.size()) stop_with_error("loader asked for an extra block");
          else check_dim("loader_j_block", exp_blocks[blk_idx], loader_j_block);
          blk_idx++;
        end
        if (start_tile) begin
          if (cmp_idx >= exp_tiles.size()) stop_with_error("compute started an extra tile");
          else check_tile("compute_tile", exp_tiles[cmp_idx], compute_tile);
          check_dim("compute_k_total", cur_dims.k, compute_k_total);
          cmp_idx++;
          outstanding++;
          if (outstanding > max_out) max_out = outstanding;
          if (outstanding > c_queue_depth + 1)
            stop_with_error("too many tiles started and not yet stored");
        end
        if (start_store) begin
          if (st_idx >= exp_tiles.size()) stop_with_error("store started an extra tile");
          else check_tile("store_tile", exp_tiles[st_idx], store_tile);
          st_idx++;
        end
        if (wr_done) begin
          if (outstanding == 0) stop_with_error("write-back finished with no tile in flight");
          outstanding--;
        end
        if (done) begin
          check_bit("busy with done", 1'b0, busy); // Falls in the same cycle
          if (blk_idx != exp_blocks.size() || cmp_idx != exp_tiles.size())
            stop_with_error("done came before all blocks and tiles were issued");
          if (st_idx != exp_tiles.size() || outstanding != 0)
            stop_with_error("done came before all tiles were written back");
          done_count++;
          last_max = max_out;
          max_out  = 0;
          blk_idx  = 0;
          cmp_idx  = 0;
          st_idx   = 0;
        end
      end
    end
  end

  // Global watchdog
  initial begin
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (limit > 0 && cycles >= limit)
        stop_with_error($sformatf("timeout, run not finished after %0d cycles", cycles));
    end
  end

  task automatic run_case(input int idx);
    int done_base;
    cur_dims   = cases[idx].d;
    slow_store = cases[idx].slow;
    build_expected(cur_dims);
    done_base = done_count;
    @(posedge clk);
    #1;
    check_bit("busy before start", 1'b0, busy);
    check_bit("done before start", 1'b0, done);
    dims  = cur_dims;
    start = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    dims  = '0;
    @(negedge clk);
    check_bit("busy after start", 1'b1, busy);
    repeat (3) @(posedge clk);
    #1;
    start = 1'b1; // Must be ignored while busy
    dims  = '{16'd1, 16'd1, 16'd1, 16'd8};
    @(posedge clk);
    #1;
    start = 1'b0;
    dims  = '0;
    while (done_count == done_base) @(posedge clk);
    repeat (4) @(posedge clk);
    #1;
    check_bit("busy after done", 1'b0, busy);
    check_bit("done after run", 1'b0, done);
    if (done_count != done_base + 1) stop_with_error("done pulsed more than once");
    if (cases[idx].slow && last_max != c_queue_depth + 1)
      stop_with_error($sformatf("compute did not stall on a full C queue, peak %0d", last_max));
  endtask

  initial begin
    int total;
    int i;
    start      = 1'b0;
    dims       = '0;
    limit      = 0;
    slow_store = 1'b0;
    cur_dims   = '0;
    void'($urandom(32'hd6c9));
    //             N       K       M       BLOCK_M
    cases[0] = '{'{16'd16, 16'd16, 16'd32, 16'd16}, 1'b0}; // Exact multiples
    cases[1] = '{'{16'd13, 16'd7,  16'd21, 16'd16}, 1'b0}; // Ragged N and M
    cases[2] = '{'{16'd8,  16'd4,  16'd8,  16'd64}, 1'b0}; // Single block
    cases[3] = '{'{16'd10, 16'd9,  16'd40, 16'd24}, 1'b0}; // M not a multiple of BLOCK_M
    cases[4] = '{'{16'd20, 16'd3,  16'd24, 16'd24}, 1'b1}; // Slow write-back
    cases[5] = '{'{16'd3,  16'd1,  16'd5,  16'd8},  1'b0}; // One tiny tile
    total = 0;
    for (i = 0; i < num_cases; i++) begin
      build_expected(cases[i].d);
      total += exp_tiles.size() * 20 + exp_blocks.size() * 10 + 50;
    end
    limit = total;
    @(posedge rstn);
    for (i = 0; i < num_cases; i++) run_case(i);
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
design/tile_pkg.sv
design/tile_queue.sv
design/block_loader.sv
design/tile_sequencer.sv
design/store_issuer.sv
design/tile_controller.sv
verification/tb_clock_gen.sv
verification/tile_controller_tb.sv

// File: Makefile
# Verilator simulation of the tile orchestrator
LOG = sim.log

sim:
	verilator --binary --timing --timescale 1ns/1ps -f vlog.f \
		--top-module tile_controller_tb -o tile_controller_tb
	./obj_dir/tile_controller_tb | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
